//--- bench/dtw_input.txt
// records: id, ref_len, flags, 8 query samples, ref_len reference samples, expected score
// flags bit 0 random gaps in sample_valid, bit 1 stray start and samples; id ffff ends
// identical query and reference
0001 0008 0000  0001 0002 0003 0004 0005 0006 0007 0008
0001 0002 0003 0004 0005 0006 0007 0008
0000
// single reference sample, vertical path only
0002 0001 0000  0003 0001 0004 0001 0005 0009 0002 0006
0004
0011
// ref_len 20, rising query
0003 0014 0000  000a 0014 001e 0028 0032 003c 0046 0050
000c 0007 0015 0014 0010 0021 001d 002a 002c 0026
0032 0033 0039 003e 003c 004a 0045 004e 0053 0051
0027
// reference shorter than query
0004 0005 0000  000b 0008 002b 0026 0016 0039 003e 001e
000a 0028 0014 003c 001e
000f
// falling query, ref_len 12
0005 000c 0000  0064 005a 0050 0046 003c 0032 0028 001e
0063 005c 0056 0050 0049 0044 003d 002e 0036 0027 0020 001b
001b
// repeats with gaps and stray traffic
0006 0014 0001  000a 0014 001e 0028 0032 003c 0046 0050
000c 0007 0015 0014 0010 0021 001d 002a 002c 0026
0032 0033 0039 003e 003c 004a 0045 004e 0053 0051
0027
0007 000c 0001  0064 005a 0050 0046 003c 0032 0028 001e
0063 005c 0056 0050 0049 0044 003d 002e 0036 0027 0020 001b
001b
0008 0001 0003  0003 0001 0004 0001 0005 0009 0002 0006
0004
0011
0009 0005 0002  000b 0008 002b 0026 0016 0039 003e 001e
000a 0028 0014 003c 001e
000f
000a 0008 0003  0001 0002 0003 0004 0005 0006 0007 0008
0001 0002 0003 0004 0005 0006 0007 0008
0000
ffff

//--- tb.f
logic/dtw_pkg.sv
logic/dtw_pe.sv
logic/dtw_array.sv
logic/dtw_step_counter.sv
logic/dtw_ctrl.sv
logic/dtw_top.sv
bench/dtw_tb.sv

//--- Bender.yml
package:
  name: dtw_scorer

sources:
  - files:
      - logic/dtw_pkg.sv
      - logic/dtw_pe.sv
      - logic/dtw_array.sv
      - logic/dtw_step_counter.sv
      - logic/dtw_ctrl.sv
      - logic/dtw_top.sv
  - target: test
    files:
      - bench/dtw_tb.sv

//--- bench/dtw_tb.sv
// testbench for the dtw scorer
// runs the records of the input file back to back and checks each final score
module dtw_tb
    import dtw_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PE    = 8;                   // query length under test
    localparam int MEM_WORDS = 512;                 // room for all record words

    logic        clk = 1'b0;
    logic        rst;
    logic        start;
    logic [15:0] ref_len;
    sample_t     sample;
    logic        sample_valid;
    logic        busy;
    logic        done;
    score_t      score;

    logic [15:0] vec [MEM_WORDS];                   // flat record words from the file
    integer      seed = 32'hf4b4;
    int          cycle_count = 0;
    int          cycle_limit = 0;                   // set from the record lengths
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;

    dtw_top #(
        .NUM_PE (NUM_PE),
        .CNT_W  (16)
    ) dut_i (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .ref_len      (ref_len),
        .sample       (sample),
        .sample_valid (sample_valid),
        .busy         (busy),
        .done         (done),
        .score        (score)
    );

    always #20 clk = ~clk;                          // 40 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the DUT did not finish within %0d cycles", cycle_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        checks++;
        if (actual !== expected) begin              // catches X too
            errors++;
            $display("ERR at %0d ns: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    function automatic logic coin_flip();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    // random word when enabled, else zero
    function automatic logic [15:0] noise(input logic enable);
        int r;
        r = $random(seed);
        return enable ? r[15:0] : 16'h0000;
    endfunction

    // sum over records of 4 x (query + reference) + 50, plus reset
    function automatic int run_budget();
        int pos;
        int total;
        pos   = 0;
        total = 16 + 10;
        while (pos < MEM_WORDS && vec[pos] != 16'hffff) begin
            total += 4 * (NUM_PE + vec[pos+1]) + 50;
            pos   += 3 + NUM_PE + vec[pos+1] + 1;
        end
        return total;
    endfunction

    task automatic drive_cycle(input logic valid, input logic [15:0] value, input logic strt,
                               input logic [15:0] len);
        @(posedge clk);
        sample_valid <= valid;
        sample       <= value;
        start        <= strt;
        ref_len      <= len;                        // only counts together with start
    endtask

    // one accepted sample, with optional random idle cycles in front
    task automatic send_sample(input sample_t value, input logic gaps, input logic junk);
        while (gaps && coin_flip()) begin
            drive_cycle(1'b0, noise(junk), junk && coin_flip(), noise(junk));
        end
        drive_cycle(1'b1, value, junk && coin_flip(), noise(junk)); // stray start while busy
    endtask

    task automatic run_record(inout int pos);
        int     id;
        int     len;
        int     qpos;
        int     i;
        int     drain;
        int     errors_before;
        logic   gaps;
        logic   junk;
        score_t expected;
        id            = vec[pos];
        len           = vec[pos+1];
        gaps          = vec[pos+2][0];              // flag bit 0
        junk          = vec[pos+2][1];              // flag bit 1
        qpos          = pos + 3;
        expected      = vec[qpos + NUM_PE + len];
        errors_before = errors;
        if (junk) begin
            repeat (3) drive_cycle(1'b1, noise(1'b1), 1'b0, noise(1'b1)); // idle samples
        end
        drive_cycle(junk, noise(junk), 1'b1, 16'(len));
        for (i = 0; i < NUM_PE; i++) begin
            send_sample(vec[qpos+i], gaps, junk);
        end
        for (i = 0; i < len; i++) begin
            send_sample(vec[qpos+NUM_PE+i], gaps, junk);
        end
        drain = -1;                                 // first pass is the accepting edge
        do begin
            drive_cycle(junk, noise(junk), junk && coin_flip(), noise(junk));
            @(negedge clk);
            drain++;
        end while (!done);
        check_eq(drain, NUM_PE + 1, "cycles from last sample to done");
        check_eq(score, expected, "score at done");
        check_eq(busy, 1'b1, "busy in the done cycle");
        drive_cycle(1'b0, noise(junk), 1'b0, noise(junk));
        @(negedge clk);
        check_eq(done, 1'b0, "done after one cycle");
        check_eq(busy, 1'b0, "busy after done");
        repeat (2) drive_cycle(junk, noise(junk), 1'b0, noise(junk));
        @(negedge clk);
        check_eq(score, expected, "score held in idle");
        tests++;
        $display("test %0d: ref_len %0d, gaps %0d, stray traffic %0d, score %0d, %s",
                 id, len, gaps, junk, score, (errors == errors_before) ? "ok" : "FAILED");
        pos = qpos + NUM_PE + len + 1;
    endtask

    initial begin
        int pos;
        rst          <= 1'b1;
        start        <= 1'b0;
        ref_len      <= 16'h0000;
        sample       <= '0;
        sample_valid <= 1'b0;
        $readmemh("bench/dtw_input.txt", vec);
        cycle_limit = run_budget();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_eq(busy, 1'b0, "busy after reset");
        check_eq(done, 1'b0, "done after reset");
        pos = 0;
        while (pos < MEM_WORDS && vec[pos] != 16'hffff) begin
            run_record(pos);                        // no reset between runs
        end
        if (tests == 0) begin
            $display("no test records were read from bench/dtw_input.txt");
            errors++;
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- logic/dtw_top.sv
// dtw scorer top level
// controller, step counter and PE array for a NUM_PE sample query
module dtw_top
    import dtw_pkg::*;
#(
    parameter int NUM_PE = 8,                   // query length
    parameter int CNT_W  = 16                   // step counter width
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,                  // pulse, ignored while busy
    input  logic [15:0] ref_len,                // sampled with start
    input  sample_t     sample,
    input  logic        sample_valid,           // strobe, gaps allowed
    output logic        busy,
    output logic        done,                   // one cycle, score valid
    output score_t      score                   // held until next start
);

    logic             count_clear;
    logic             count_inc;
    logic [CNT_W-1:0] count_limit;
    logic [CNT_W-1:0] count;                    // also the query write index
    logic             last;
    logic             load_we;
    logic             stream_valid;
    logic             array_clear;

    dtw_ctrl #(
        .NUM_PE (NUM_PE)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .sample_valid (sample_valid),
        .ref_len      (ref_len),
        .last         (last),
        .count_clear  (count_clear),
        .count_inc    (count_inc),
        .count_limit  (count_limit),
        .load_we      (load_we),
        .stream_valid (stream_valid),
        .array_clear  (array_clear),
        .busy         (busy),
        .done         (done)
    );

    dtw_step_counter #(
        .CNT_W (CNT_W)
    ) u_counter (
        .clk   (clk),
        .rst   (rst),
        .clear (count_clear),
        .inc   (count_inc),
        .limit (count_limit),
        .count (count),
        .last  (last)
    );

    dtw_array #(
        .NUM_PE (NUM_PE)
    ) u_array (
        .clk          (clk),
        .rst          (rst),
        .clear        (array_clear),
        .load_we      (load_we),
        .stream_valid (stream_valid),
        .load_idx     (count),
        .sample       (sample),
        .score        (score)
    );

endmodule

//--- logic/dtw_ctrl.sv
// dtw run controller
// steps through load, stream and drain, gates the samples, flags done and busy
module dtw_ctrl
    import dtw_pkg::*;
#(
    parameter int NUM_PE = 8                    // query length
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,                  // run request, IDLE only
    input  logic        sample_valid,           // sample strobe from source
    input  logic [15:0] ref_len,                // reference length, taken with start
    input  logic        last,                   // counter reached the phase end
    output logic        count_clear,            // pulse at each phase change
    output logic        count_inc,
    output logic [15:0] count_limit,
    output logic        load_we,                // query sample write
    output logic        stream_valid,           // reference sample into the array
    output logic        array_clear,            // wipe PE scores for a new run
    output logic        busy,
    output logic        done
);

    dtw_state_e  state_q;
    dtw_state_e  state_d;
    logic [15:0] ref_len_q;                     // latched at start

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && start) begin
            ref_len_q <= ref_len;               // ref_len is at least 1
        end
    end

    always_comb begin
        state_d      = state_q;
        count_clear  = 1'b0;
        count_inc    = 1'b0;
        count_limit  = 16'(NUM_PE);
        load_we      = 1'b0;
        stream_valid = 1'b0;
        unique case (state_q)
            IDLE: begin
                if (start) begin                // samples here are dropped
                    state_d     = LOAD;
                    count_clear = 1'b1;
                end
            end
            LOAD: begin
                load_we   = sample_valid;       // count gives the query index
                count_inc = sample_valid;
                if (last) begin
                    state_d     = STREAM;
                    count_clear = 1'b1;
                end
            end
            STREAM: begin
                stream_valid = sample_valid;
                count_inc    = sample_valid;
                count_limit  = ref_len_q;
                if (last) begin
                    state_d     = DRAIN;
                    count_clear = 1'b1;
                end
            end
            DRAIN: begin
                count_inc   = 1'b1;             // free running, one step per clock
                count_limit = 16'(NUM_PE + 1);  // head register plus NUM_PE PEs
                if (last) begin
                    state_d     = DONE;
                    count_clear = 1'b1;
                end
            end
            DONE: begin
                state_d = IDLE;                 // single cycle
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign array_clear = (state_q == IDLE) && start;
    assign busy        = (state_q != IDLE);     // includes the done cycle
    assign done        = (state_q == DONE);

endmodule

//--- logic/dtw_step_counter.sv
// loadable step counter for the controller phases
// counts inc strobes up to limit and wraps to zero with last
module dtw_step_counter #(
    parameter int CNT_W = 16                    // counter width
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             clear,             // phase change, back to zero
    input  logic             inc,               // one step
    input  logic [CNT_W-1:0] limit,             // steps in this phase
    output logic [CNT_W-1:0] count,             // steps taken so far
    output logic             last               // final step of the phase
);

    logic [CNT_W-1:0] count_q;

    assign last  = inc && (count_q == limit - CNT_W'(1));
    assign count = count_q;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            count_q <= '0;
        end else if (last) begin
            count_q <= '0;                      // wrap so the next phase starts clean
        end else if (inc) begin
            count_q <= count_q + CNT_W'(1);
        end
    end

endmodule

//--- logic/dtw_array.sv
// systolic chain of dtw PEs with the query store
// reference samples enter at PE 0 and the full score leaves the last PE
module dtw_array
    import dtw_pkg::*;
#(
    parameter int NUM_PE = 8                    // query length with one PE per row
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        clear,                  // start of a run
    input  logic        load_we,                // query write strobe
    input  logic        stream_valid,           // reference sample enters
    input  logic [15:0] load_idx,               // query write index
    input  sample_t     sample,                 // shared sample input
    output score_t      score                   // last PE's cell score
);

    sample_t  query_q [NUM_PE];                 // one query sample per PE
    pe_link_t link [NUM_PE+1];                  // link[i] feeds PE i
    logic     head_valid_q;                     // sample accepted last edge
    sample_t  head_y_q;

    // query store written in order during load
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_PE; i++) begin
            if (load_we && load_idx == 16'(i)) begin
                query_q[i] <= sample;
            end
        end
    end

    // incoming reference sample is registered so PE 0 acts one edge later
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            head_valid_q <= 1'b0;
        end else begin
            head_valid_q <= stream_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (stream_valid) begin
            head_y_q <= sample;                 // latest reference sample
        end
    end

    // row -1 lies outside the matrix so north is infinite for PE 0
    assign link[0] = '{valid: head_valid_q, y: head_y_q, score: SCORE_MAX};

    for (genvar i = 0; i < NUM_PE; i++) begin : g_pe
        // D(-1,-1) = 0 enters as PE 0's north-west while other rows start at infinity
        localparam score_t NW_SEED = (i == 0) ? '0 : SCORE_MAX;

        dtw_pe u_pe (
            .clk      (clk),
            .rst      (rst),
            .clear    (clear),
            .nw_init  (NW_SEED),
            .x        (query_q[i]),
            .link_in  (link[i]),
            .link_out (link[i+1])
        );
    end

    // D(NUM_PE-1, j) for the latest j held across bubbles
    assign score = link[NUM_PE].score;

endmodule

//--- logic/dtw_pe.sv
// dtw processing element that computes one row of the warping matrix
// cell score is |x - y| plus the min of north, west and north-west
module dtw_pe
    import dtw_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     clear,                     // new run drops old scores
    input  score_t   nw_init,                   // north-west seed after clear
    input  sample_t  x,                         // query sample of this row
    input  pe_link_t link_in,                   // from the PE above
    output pe_link_t link_out                   // to the PE below
);

    score_t  cost;                              // absolute sample distance
    score_t  min_n_w;                           // min of north and west
    score_t  min3;                              // min of all three neighbours
    score_t  score_q;                           // own last cell as the west value
    score_t  nw_q;                              // previous north as the north-west value
    sample_t y_q;                               // forwarded reference sample
    logic    valid_q;

    // absolute difference of two unsigned samples
    assign cost    = (x > link_in.y) ? x - link_in.y : link_in.y - x;
    assign min_n_w = (link_in.score < score_q) ? link_in.score : score_q;
    assign min3    = (nw_q < min_n_w) ? nw_q : min_n_w;

    always_ff @(posedge clk) begin
        if (rst) begin
            score_q <= SCORE_MAX;               // west edge at infinity
            nw_q    <= SCORE_MAX;
            valid_q <= 1'b0;
        end else if (clear) begin
            score_q <= SCORE_MAX;
            nw_q    <= nw_init;                 // corner only for row 0
            valid_q <= 1'b0;
        end else begin
            valid_q <= link_in.valid;           // bubbles pass as bubbles
            if (link_in.valid) begin
                score_q <= cost + min3;         // wraps at 16 bits
                nw_q    <= link_in.score;       // north now and north-west next time
            end
        end
    end

    always_ff @(posedge clk) begin
        if (link_in.valid) begin
            y_q <= link_in.y;                   // hold y across bubbles
        end
    end

    assign link_out = '{valid: valid_q, y: y_q, score: score_q};

endmodule

//--- logic/dtw_pkg.sv
// dtw scorer shared types
// sample and score words, the PE-to-PE link and controller states
package dtw_pkg;

    parameter int WORD_W = 16;                  // sample and score width

    typedef logic [WORD_W-1:0] sample_t;        // one signal sample, unsigned
    typedef logic [WORD_W-1:0] score_t;         // one DTW cell score

    // stands for infinity at the matrix edges
    parameter score_t SCORE_MAX = '1;

    // what one PE hands to the next, 33 bits
    typedef struct packed {
        logic    valid;                         // a reference sample is present
        sample_t y;                             // reference sample
        score_t  score;                         // sender's new cell score
    } pe_link_t;

    // controller phases
    typedef enum logic [2:0] {
        IDLE   = 3'd0,                          // waiting for start
        LOAD   = 3'd1,                          // query samples come in
        STREAM = 3'd2,                          // reference samples come in
        DRAIN  = 3'd3,                          // last sample walks the chain
        DONE   = 3'd4                           // result valid, one cycle
    } dtw_state_e;

endpackage
